// ==== sources.f ====
src/pixel_pkg.sv
src/window_pkg.sv
src/column_capture.sv
src/window_shift.sv
src/cross_filter.sv
src/array_flow_top.sv
tb/array_flow_sva.sv
tb/array_flow_tb.sv

// ==== src/array_flow_top.sv ====
module array_flow_top #(
    parameter int detail_thresh = 102
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  col_valid,
    input  window_pkg::column_t   col,
    input  window_pkg::repl_t     repl,
    input  window_pkg::row_idx_t  row_idx,
    output logic                  out_valid,
    output pixel_pkg::pix_word_t  out_word
);

    import window_pkg::*;

    logic    cap_valid;
    column_t cap_col;
    logic    win_valid;
    window_t win;

    // Column in, line replacement on the top rows
    column_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .col_valid (col_valid),
        .col       (col),
        .repl      (repl),
        .row_idx   (row_idx),
        .cap_valid (cap_valid),
        .cap_col   (cap_col)
    );

    window_shift u_shift (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .cap_col   (cap_col),
        .win_valid (win_valid),
        .win       (win)
    );

    cross_filter #(
        .detail_thresh (detail_thresh)
    ) u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win       (win),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

// ==== src/column_capture.sv ====
module column_capture (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  col_valid,
    input  window_pkg::column_t   col,
    input  window_pkg::repl_t     repl,
    input  window_pkg::row_idx_t  row_idx,
    output logic                  cap_valid,
    output window_pkg::column_t   cap_col
);

    import window_pkg::*;

    column_t sel_col;

    // Processed lines re-enter the top of the window as the frame moves down
    always_comb begin
        sel_col = col;
        for (int s = 0; s < repl_rows; s++) begin
            if (row_idx >= repl_min[s]) begin
                sel_col.slot[s] = repl.line[s];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= col_valid;  // One cycle strobe, no back-pressure
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_col <= '0;
        end else if (col_valid) begin
            cap_col <= sel_col;  // Held between strobes
        end
    end

endmodule

// ==== src/cross_filter.sv ====
module cross_filter #(
    parameter int detail_thresh = 102
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 win_valid,
    input  window_pkg::window_t  win,
    output logic                 out_valid,
    output pixel_pkg::pix_word_t out_word
);

    import pixel_pkg::*;
    import window_pkg::*;

    localparam int c_row = win_rows / 2;  // Row 3
    localparam int c_col = win_cols / 2;  // Column 6

    pix_word_t centre;
    pix_word_t up_word;
    pix_word_t dn_word;
    pix_word_t lf_word;
    pix_word_t rt_word;
    pix_word_t avg_word;

    logic [lanes-1:0][lane_w+1:0] lane_sum;  // Two guard bits for four terms
    logic [lanes-1:0][lane_w-1:0] detail;
    logic [lane_w-1:0]            max_detail;
    logic                         sel_avg;

    // Centre cross
    assign centre  = win[c_col].slot[c_row];
    assign up_word = win[c_col].slot[c_row-1];
    assign dn_word = win[c_col].slot[c_row+1];
    assign lf_word = win[c_col-1].slot[c_row];
    assign rt_word = win[c_col+1].slot[c_row];

    always_comb begin
        max_detail = '0;
        for (int l = 0; l < lanes; l++) begin
            lane_sum[l] = {2'b00, up_word.lane[l]} + {2'b00, dn_word.lane[l]}
                        + {2'b00, lf_word.lane[l]} + {2'b00, rt_word.lane[l]};
            avg_word.lane[l] = lane_sum[l][lane_w+1:2];  // Truncating divide by four

            if (centre.lane[l] > avg_word.lane[l]) begin
                detail[l] = centre.lane[l] - avg_word.lane[l];
            end else begin
                detail[l] = avg_word.lane[l] - centre.lane[l];
            end

            if (detail[l] > max_detail) begin
                max_detail = detail[l];
            end
        end
    end

    // Strong local detail takes the smoothed word
    assign sel_avg = (max_detail > detail_thresh);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= win_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_word <= '0;
        end else if (win_valid) begin
            out_word <= sel_avg ? avg_word : centre;
        end
    end

endmodule

// ==== src/pixel_pkg.sv ====
package pixel_pkg;

    localparam int lane_w = 10;  // Bits per pixel lane
    localparam int lanes  = 4;   // Pixel lanes per word

    typedef logic [lane_w-1:0] lane_t;

    // Four lanes side by side, lane 0 in the low bits
    typedef struct packed {
        lane_t [lanes-1:0] lane;
    } pix_word_t;

endpackage

// ==== src/window_pkg.sv ====
package window_pkg;

    import pixel_pkg::*;

    // Neighbourhood geometry
    localparam int win_rows  = 7;
    localparam int win_cols  = 13;
    localparam int repl_rows = 3;  // Top rows that may take replacement lines

    typedef logic [3:0] row_idx_t;  // Row counter of the frame

    // Slot s takes its replacement line once row_idx reaches repl_min[s]
    localparam row_idx_t repl_min [0:repl_rows-1] = '{4'd3, 4'd2, 4'd1};

    // One column of the window, slot 0 is the top row
    typedef struct packed {
        pix_word_t [win_rows-1:0] slot;
    } column_t;

    typedef struct packed {
        pix_word_t [repl_rows-1:0] line;  // Line s feeds slot s
    } repl_t;

    // Column 0 holds the oldest data, column win_cols-1 the newest
    typedef column_t [win_cols-1:0] window_t;

endpackage

// ==== src/window_shift.sv ====
module window_shift (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cap_valid,
    input  window_pkg::column_t  cap_col,
    output logic                 win_valid,
    output window_pkg::window_t  win
);

    import window_pkg::*;

    localparam int fill_w = $clog2(win_cols + 1);
    localparam logic [fill_w-1:0] fill_full = fill_w'(win_cols);

    logic [fill_w-1:0] fill_cnt;
    logic              fill_next_full;

    // Counter reaches full with the shift that is happening now
    assign fill_next_full = (fill_cnt >= fill_full - 1'b1);

    // Number of real columns in the window, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (cap_valid && fill_cnt != fill_full) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= cap_valid && fill_next_full;
        end
    end

    // Oldest column drops out at column 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win <= '0;
        end else if (cap_valid) begin
            win <= {cap_col, win[win_cols-1:1]};
        end
    end

endmodule

// ==== tb/array_flow_sva.sv ====
module array_flow_sva (
    input logic clk,
    input logic rst_n,
    input logic col_valid,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // Every output belongs to a column strobe three cycles back
    a_out_latency: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(col_valid, 3)
    ) else $error("out_valid without a col_valid three cycles earlier");

    a_quiet_in_reset: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else $error("out_valid high during reset");

    a_quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !out_valid
    ) else $error("out_valid high in the first cycle after reset");

endmodule

bind array_flow_top array_flow_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_valid (col_valid),
    .out_valid (out_valid)
);

// ==== tb/array_flow_tb.sv ====
module array_flow_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import pixel_pkg::*;
    import window_pkg::*;

    localparam int    out_timeout  = 20;  // Cycles from strobe to out_valid with margin
    localparam int    idle_timeout = 50;
    localparam string trace_path   = "tb/array_flow_trace.txt";

    logic      clk;
    logic      rst_n;
    logic      col_valid;
    column_t   col;
    repl_t     repl;
    row_idx_t  row_idx;
    logic      out_valid;
    pix_word_t out_word;

    int        cyc = 0;
    bit        all_driven = 0;
    bit        check_done = 0;

    // One entry per strobe, in order
    int        due_q[$];
    bit        flag_q[$];
    pix_word_t exp_q[$];

    array_flow_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .col_valid (col_valid),
        .col       (col),
        .repl      (repl),
        .row_idx   (row_idx),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compare_val(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    initial begin : stimulus
        int          fd;
        int          n;
        int          t;
        int          lines_read;
        string       line;
        logic [63:0] f [14];

        rst_n      = 1'b0;
        col_valid  = 1'b0;
        col        = '0;
        repl       = '0;
        row_idx    = '0;
        lines_read = 0;

        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file");
        end

        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;  // Header or blank line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n != 14) begin
                abort_run("Malformed line in the trace file");
            end

            repeat (int'(f[0])) begin  // Idle gap
                @(posedge clk);
                #1;
            end

            row_idx = f[1][3:0];
            for (int s = 0; s < win_rows; s++) begin
                col.slot[s] = f[2+s][39:0];
            end
            for (int s = 0; s < repl_rows; s++) begin
                repl.line[s] = f[9+s][39:0];
            end
            col_valid = 1'b1;
            due_q.push_back(cyc + 3);
            flag_q.push_back(f[12][0]);
            exp_q.push_back(f[13][39:0]);
            lines_read++;

            @(posedge clk);
            #1 col_valid = 1'b0;
        end
        $fclose(fd);
        all_driven = 1'b1;

        t = 0;
        while (!check_done) begin
            @(negedge clk);
            t++;
            if (t > idle_timeout) begin
                abort_run("Checker did not finish after the last column");
            end
        end

        // Nothing may follow the last expected word
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            if (out_valid) begin
                abort_run("out_valid rose after the last column was checked");
            end
        end

        if (lines_read > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : output_check
        int        t;
        int        due;
        bit        flag;
        pix_word_t exp;

        while (!check_done) begin
            t = 0;
            while (due_q.size() == 0 && !all_driven) begin
                @(negedge clk);
                if (out_valid) begin
                    abort_run("out_valid rose with no column in flight");
                end
                t++;
                if (t > idle_timeout) begin
                    abort_run("Timed out waiting for the next column");
                end
            end

            if (due_q.size() == 0) begin
                check_done = 1'b1;
            end else begin
                due  = due_q.pop_front();
                flag = flag_q.pop_front();
                exp  = exp_q.pop_front();
                if (flag) begin
                    t = 0;
                    do begin
                        @(negedge clk);
                        t++;
                        if (t > out_timeout) begin
                            abort_run("Timed out waiting for out_valid");
                        end
                    end while (!out_valid);
                    compare_val("out_valid_cycle", cyc, due);  // Fixed 3 cycle latency
                    compare_val("out_word", out_word, exp);
                end
            end
        end
    end

endmodule

// ==== tb/array_flow_trace.txt ====
# gap row_idx slot0 slot1 slot2 slot3 slot4 slot5 slot6 repl0 repl1 repl2 expect expected_word
# all hex, one column strobe per line, words are four 10-bit lanes with lane 0 lowest
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
2 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 4010040100 0000000000 0000000000 0000000000 0 0000000000
0 0 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 0000000000 0000000000 0000000000 0 0000000000
0 0 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 0000000000 0000000000 0000000000 0 0000000000
0 0 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 C0300C0300 0000000000 0000000000 0000000000 0 0000000000
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 0 0000000000
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 4010040100
0 1 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 6018060180
0 2 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 C0300C0300 4010040100 1 A0280A0280
3 3 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 C0300C0300 C0300C0300 0000000000 1 C0300C0300
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 C0300C0300
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 8020080200
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 8020080200
1 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 6018060180
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 8020080200
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 6018060180
0 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 8020080200
4 0 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 8020080200 0000000000 0000000000 0000000000 1 8020080200
